//--- verilog/mul_macros.svh
`ifndef MUL_MACROS_SVH
`define MUL_MACROS_SVH

////////////////////
// Datapath widths
////////////////////

// Two's complement operand
`define MUL_OP_W 8

// Operand magnitude after the -128 clamp
`define MUL_MAG_W 7

// Magnitude product, 127*127 fits
`define MUL_SUM_W 14

// Signed product
`define MUL_PROD_W 16

////////////////////
// Pipeline
////////////////////

// Capture edge to out_valid, in clock cycles
`define MUL_LATENCY 3

`endif

//--- verilog/mul_types_pkg.sv
`include "mul_macros.svh"

package mul_types_pkg;

    typedef logic [`MUL_OP_W-1:0]   operand_t;
    typedef logic [`MUL_MAG_W-1:0]  mag_t;
    typedef logic [`MUL_SUM_W-1:0]  sum_t;
    typedef logic [`MUL_PROD_W-1:0] prod_t;

    typedef struct packed {
        logic sign;
        mag_t mag;
    } sm_operand_t;

    // Slices of a magnitude: 0 is [2:0], 3 is [4:3], 5 is [6:5]
    typedef struct packed {
        logic [5:0] a0b0;
        logic [4:0] a3b0;
        logic [4:0] a5b0;
        logic [4:0] a0b3;
        logic [4:0] a0b5;
        logic [3:0] a3b3;
        logic [3:0] a5b3;
        logic [3:0] a3b5;
        logic [3:0] a5b5;
    } slice_prods_t;

endpackage

//--- verilog/mul_ctrl_pkg.sv
package mul_ctrl_pkg;

    ////////////////////
    // Term drop
    ////////////////////

    // Which weight-2^5 cross term is left out of the sum
    typedef enum logic [1:0] {
        DROP_NONE = 2'd0,
        DROP_A0B5 = 2'd1,
        DROP_A5B0 = 2'd2
    } pp_drop_t;

    ////////////////////
    // Stage control
    ////////////////////

    typedef struct packed {
        logic     valid;
        logic     sign;
        pp_drop_t drop;
    } stage_ctl_t;

endpackage

//--- verilog/sm_operand_conv.sv
`timescale 1ns/1ps

`include "mul_macros.svh"

module sm_operand_conv import mul_types_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        en,
    input  operand_t    x,
    output sm_operand_t sm
);

    operand_t    x_neg;
    logic        is_min;
    sm_operand_t sm_d;

    // -128 has no 7-bit magnitude
    assign is_min = (x == {1'b1, {(`MUL_OP_W-1){1'b0}}});
    assign x_neg  = -x;

    always_comb begin
        sm_d.sign = x[`MUL_OP_W-1];
        if (!x[`MUL_OP_W-1])
            sm_d.mag = x[`MUL_MAG_W-1:0];
        else if (is_min)
            sm_d.mag = {`MUL_MAG_W{1'b1}};
        else
            sm_d.mag = x_neg[`MUL_MAG_W-1:0];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            sm <= '0;
        else if (en)
            sm <= sm_d;
    end

    a_clamp_mag: assert property (@(posedge clk) disable iff (!rst_n)
        en && is_min |=> sm.sign && (sm.mag == {`MUL_MAG_W{1'b1}}));

endmodule

//--- verilog/pp_array.sv
`timescale 1ns/1ps

module pp_array import mul_types_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         en,
    input  mag_t         mag_a,
    input  mag_t         mag_b,
    output slice_prods_t slices
);

    logic [2:0]   a0;
    logic [1:0]   a3;
    logic [1:0]   a5;
    logic [2:0]   b0;
    logic [1:0]   b3;
    logic [1:0]   b5;
    slice_prods_t slices_d;

    ////////////////////
    // 3/2/2 split
    ////////////////////

    assign a0 = mag_a[2:0];
    assign a3 = mag_a[4:3];
    assign a5 = mag_a[6:5];
    assign b0 = mag_b[2:0];
    assign b3 = mag_b[4:3];
    assign b5 = mag_b[6:5];

    ////////////////////
    // Slice products
    ////////////////////

    always_comb begin
        // 3x3
        slices_d.a0b0 = {3'b000, a0} * {3'b000, b0};

        // 2x3 and 3x2, weight 2^3
        slices_d.a3b0 = {3'b000, a3} * {2'b00, b0};
        slices_d.a0b3 = {2'b00, a0} * {3'b000, b3};

        // 2x3 and 3x2, weight 2^5
        slices_d.a5b0 = {3'b000, a5} * {2'b00, b0};
        slices_d.a0b5 = {2'b00, a0} * {3'b000, b5};

        // 2x2
        slices_d.a3b3 = {2'b00, a3} * {2'b00, b3};
        slices_d.a5b3 = {2'b00, a5} * {2'b00, b3};
        slices_d.a3b5 = {2'b00, a3} * {2'b00, b5};
        slices_d.a5b5 = {2'b00, a5} * {2'b00, b5};
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            slices <= '0;
        else if (en)
            slices <= slices_d;
    end

endmodule

//--- verilog/pp_sum.sv
`timescale 1ns/1ps

`include "mul_macros.svh"

module pp_sum import mul_types_pkg::*, mul_ctrl_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         en,
    input  slice_prods_t slices,
    input  stage_ctl_t   ctl,
    output prod_t        p
);

    logic [`MUL_SUM_W-1:0] row_diag;
    logic [9:0]            row_cross;
    logic [4:0]            hi_a5b0;
    logic [4:0]            hi_a0b5;
    logic [5:0]            row_hi;
    logic [`MUL_SUM_W:0]   total;
    sum_t                  mag;
    prod_t                 mag_ext;
    prod_t                 p_d;

    ////////////////////
    // Rows
    ////////////////////

    // Diagonal terms do not overlap
    assign row_diag  = {slices.a5b5, slices.a3b3, slices.a0b0};

    // Weight 2^3 pairs
    assign row_cross = {1'b0, slices.a5b3, slices.a3b0} + {1'b0, slices.a3b5, slices.a0b3};

    // Weight 2^5 terms, one may be dropped
    assign hi_a5b0 = (ctl.drop == DROP_A5B0) ? 5'd0 : slices.a5b0;
    assign hi_a0b5 = (ctl.drop == DROP_A0B5) ? 5'd0 : slices.a0b5;
    assign row_hi  = {1'b0, hi_a5b0} + {1'b0, hi_a0b5};

    assign total = {1'b0, row_diag}
                 + {2'b00, row_cross, 3'b000}
                 + {4'h0, row_hi, 5'b00000};
    assign mag   = total[`MUL_SUM_W-1:0];

    ////////////////////
    // Sign and output
    ////////////////////

    assign mag_ext = {{(`MUL_PROD_W-`MUL_SUM_W){1'b0}}, mag};
    assign p_d     = ctl.sign ? -mag_ext : mag_ext;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            p <= '0;
        else if (en)
            p <= p_d;
    end

    a_no_carry: assert property (@(posedge clk) disable iff (!rst_n)
        ctl.valid |-> !total[`MUL_SUM_W]);

endmodule

//--- verilog/mul_ctrl.sv
`timescale 1ns/1ps

module mul_ctrl import mul_ctrl_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       in_valid,
    input  logic       approx_en,
    input  logic       a_sign,
    input  logic       b_sign,
    output logic       en_s1,
    output logic       en_s2,
    output logic       en_s3,
    output stage_ctl_t ctl_s2,
    output logic       out_valid
);

    stage_ctl_t ctl_d;
    stage_ctl_t ctl_s1;

    ////////////////////
    // Per-op control
    ////////////////////

    always_comb begin
        ctl_d.valid = in_valid;
        ctl_d.sign  = a_sign ^ b_sign;
        // Keep the cross term on the side of the sign of b
        if (!in_valid || !approx_en)
            ctl_d.drop = DROP_NONE;
        else if (b_sign)
            ctl_d.drop = DROP_A5B0;
        else
            ctl_d.drop = DROP_A0B5;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctl_s1    <= '{valid: 1'b0, sign: 1'b0, drop: DROP_NONE};
            ctl_s2    <= '{valid: 1'b0, sign: 1'b0, drop: DROP_NONE};
            out_valid <= 1'b0;
        end else begin
            ctl_s1    <= ctl_d;
            ctl_s2    <= ctl_s1;
            out_valid <= ctl_s2.valid;
        end
    end

    // Datapath stage enables
    assign en_s1 = in_valid;
    assign en_s2 = ctl_s1.valid;
    assign en_s3 = ctl_s2.valid;

    a_out_valid_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(out_valid));

    a_drop_s2_valid: assert property (@(posedge clk) disable iff (!rst_n)
        (ctl_s2.drop != DROP_NONE) |-> ctl_s2.valid);

endmodule

//--- verilog/approx_mul_top.sv
`timescale 1ns/1ps

module approx_mul_top import mul_types_pkg::*, mul_ctrl_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  logic     approx_en,
    input  operand_t a,
    input  operand_t b,
    output logic     out_valid,
    output prod_t    p
);

    logic         en_s1;
    logic         en_s2;
    logic         en_s3;
    stage_ctl_t   ctl_s2;
    sm_operand_t  sm_a;
    sm_operand_t  sm_b;
    slice_prods_t slices;

    mul_ctrl u_mul_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .approx_en (approx_en),
        .a_sign    (a[$high(a)]),
        .b_sign    (b[$high(b)]),
        .en_s1     (en_s1),
        .en_s2     (en_s2),
        .en_s3     (en_s3),
        .ctl_s2    (ctl_s2),
        .out_valid (out_valid)
    );

    ////////////////////
    // Datapath
    ////////////////////

    sm_operand_conv u_conv_a (.clk(clk), .rst_n(rst_n), .en(en_s1), .x(a), .sm(sm_a));
    sm_operand_conv u_conv_b (.clk(clk), .rst_n(rst_n), .en(en_s1), .x(b), .sm(sm_b));

    pp_array u_pp_array (
        .clk    (clk),
        .rst_n  (rst_n),
        .en     (en_s2),
        .mag_a  (sm_a.mag),
        .mag_b  (sm_b.mag),
        .slices (slices)
    );

    pp_sum u_pp_sum (.clk(clk), .rst_n(rst_n), .en(en_s3), .slices(slices), .ctl(ctl_s2), .p(p));

endmodule

//--- verif/tb_approx_mul.sv
`timescale 1ns/1ps

`include "mul_macros.svh"

module tb_approx_mul import mul_types_pkg::*; ();

    localparam int CLK_PERIOD      = 100;
    localparam int RESET_CYCLES    = 3;
    localparam int IDLE_CYCLES     = 8;
    localparam int N_EXACT         = 300;
    localparam int N_APPROX        = 300;
    localparam int N_CORNER        = 72;
    localparam int N_BURST         = 20;
    localparam int N_MIXED         = 200;
    localparam int STIM_CYCLES     = IDLE_CYCLES + N_EXACT + N_APPROX + N_CORNER
                                   + N_BURST + N_MIXED;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + STIM_CYCLES + `MUL_LATENCY + 10;

    logic     clk;
    logic     rst_n;
    logic     in_valid;
    logic     approx_en;
    operand_t a;
    operand_t b;
    logic     out_valid;
    prod_t    p;

    logic [31:0] lfsr = 32'h52c9_7fd7;
    prod_t       exp_q[$];
    prod_t       exp_p = '0;
    int          results_seen = 0;
    int          n_drop_nz = 0;
    int          n_b_neg = 0;
    int          n_b_pos = 0;

    // 0, 1, -1, 127, -127, -128
    operand_t corners [6] = '{8'h00, 8'h01, 8'hff, 8'h7f, 8'h81, 8'h80};

    approx_mul_top u_approx_mul_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .approx_en (approx_en),
        .a         (a),
        .b         (b),
        .out_valid (out_valid),
        .p         (p)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////
    // Random source
    ////////////////////

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0])
            return (s >> 1) ^ 32'h8020_0003;
        return s >> 1;
    endfunction

    function automatic logic rand_bit();
        logic bit_out;
        bit_out = lfsr[0];
        lfsr = lfsr_next(lfsr);
        return bit_out;
    endfunction

    function automatic operand_t rand_byte();
        operand_t v;
        v = '0;
        for (int k = 0; k < 8; k++)
            v = {v[6:0], rand_bit()};
        return v;
    endfunction

    ////////////////////
    // Reference model
    ////////////////////

    function automatic int clamped_mag(input operand_t x);
        int v;
        v = {{24{x[7]}}, x};
        if (v == -128)
            v = -127;
        return (v < 0) ? -v : v;
    endfunction

    // Weight 2^5 term left out in approximate mode
    function automatic int dropped_term(input operand_t x, input operand_t y);
        int ma;
        int mb;
        ma = clamped_mag(x);
        mb = clamped_mag(y);
        if (y[7])
            return ((ma >> 5) & 3) * (mb & 7) * 32;
        return (ma & 7) * ((mb >> 5) & 3) * 32;
    endfunction

    function automatic prod_t ref_product(input operand_t x, input operand_t y, input logic ap);
        int m;
        m = clamped_mag(x) * clamped_mag(y);
        if (ap)
            m = m - dropped_term(x, y);
        if (x[7] ^ y[7])
            m = -m;
        return m[15:0];
    endfunction

    ////////////////////
    // Run control
    ////////////////////

    task automatic abort_run();
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input prod_t got, input prod_t expected);
        $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, expected);
        abort_run();
    endtask

    task automatic drive_op(input logic v, input operand_t x, input operand_t y, input logic ap);
        @(posedge clk);
        #1;
        in_valid  = v;
        a         = x;
        b         = y;
        approx_en = ap;
        if (v) begin
            exp_q.push_back(ref_product(x, y, ap));
            if (ap) begin
                if (dropped_term(x, y) != 0)
                    n_drop_nz++;
                if (y[7])
                    n_b_neg++;
                else
                    n_b_pos++;
            end
        end
    endtask

    task automatic drive_random(input logic v, input logic ap);
        operand_t x;
        operand_t y;
        x = rand_byte();
        y = rand_byte();
        drive_op(v, x, y, ap);
    endtask

    // Expected result for the cycle ahead
    always @(negedge clk) begin
        if (rst_n && out_valid) begin
            if (exp_q.size() == 0) begin
                $display("out_valid was high with no operation in flight");
                abort_run();
            end else begin
                exp_p = exp_q.pop_front();
                results_seen++;
            end
        end
    end

    ////////////////////
    // Checks
    ////////////////////

    a_out_valid: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid == $past(in_valid, `MUL_LATENCY))
        else report_mismatch("out_valid", {15'd0, $sampled(out_valid)},
                             {15'd0, !$sampled(out_valid)});

    a_p_value: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> p == exp_p)
        else report_mismatch("p", $sampled(p), $sampled(exp_p));

    a_p_reset: assert property (@(posedge clk) disable iff (!rst_n)
        (results_seen == 0) |-> p == '0)
        else report_mismatch("p", $sampled(p), 16'h0000);

    a_p_hold: assert property (@(posedge clk) disable iff (!rst_n)
        !out_valid |-> p == $past(p))
        else begin
            $display("p changed while out_valid was low");
            abort_run();
        end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        abort_run();
    end

    initial begin
        logic v_bit;
        logic ap_bit;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        approx_en = 1'b0;
        a         = '0;
        b         = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Operands move without a strobe after reset
        repeat (IDLE_CYCLES) drive_random(1'b0, 1'b1);

        for (int i = 0; i < N_EXACT; i++)
            drive_random(1'b1, 1'b0);
        for (int i = 0; i < N_APPROX; i++)
            drive_random(1'b1, 1'b1);

        for (int md = 0; md < 2; md++)
            for (int i = 0; i < 6; i++)
                for (int j = 0; j < 6; j++)
                    drive_op(1'b1, corners[i], corners[j], md != 0);

        // Back-to-back strobes followed by random gaps
        for (int i = 0; i < N_BURST; i++)
            drive_random(1'b1, rand_bit());
        for (int i = 0; i < N_MIXED; i++) begin
            v_bit  = rand_bit();
            ap_bit = rand_bit();
            drive_random(v_bit, ap_bit);
        end

        repeat (`MUL_LATENCY + 2) drive_op(1'b0, '0, '0, 1'b0);

        if (exp_q.size() != 0 || n_drop_nz == 0 || n_b_neg == 0 || n_b_pos == 0) begin
            $display("run ended with %0d results outstanding or a drop case never reached",
                     exp_q.size());
            abort_run();
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

//--- sim.f
+incdir+verilog
verilog/mul_types_pkg.sv
verilog/mul_ctrl_pkg.sv
verilog/sm_operand_conv.sv
verilog/pp_array.sv
verilog/pp_sum.sv
verilog/mul_ctrl.sv
verilog/approx_mul_top.sv
verif/tb_approx_mul.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the multiplier testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert --timing -j 0 \
    -f sim.f \
    --top-module tb_approx_mul \
    -Mdir obj_dir

# The log decides the verdict, so a fatal exit must not stop the script here
./obj_dir/Vtb_approx_mul > sim.log 2>&1 || true
cat sim.log

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
    echo "Simulation failed"
    exit 1
fi

echo "Simulation done"
exit 0
